/* hdl/hordePkg.sv */
// Shared constants and types for the enemy horde.
// Coordinates are unsigned screen pixels with y growing downward, so North means smaller y.
// The readout word is 32 bits. The alive-mask view pads the upper bits with zeros.
package hordePkg;

    localparam int NumEnemies = 10;
    localparam int CoordW     = 10;
    localparam int HpW        = 7;

    // Arena limits, inclusive
    localparam logic [CoordW-1:0] ArenaXMax = 10'd640;
    localparam logic [CoordW-1:0] ArenaYMax = 10'd480;

    localparam logic [CoordW-1:0] SpawnXEven = 10'd632;  // Right edge, walks West
    localparam logic [CoordW-1:0] SpawnXOdd  = 10'd0;    // Left edge, walks East
    localparam logic [CoordW-1:0] SpawnY     = 10'd240;
    localparam logic [HpW-1:0]    SpawnHp    = 7'd127;

    localparam logic [CoordW-1:0] ChaseStep   = 10'd1;
    localparam logic [CoordW-1:0] KnockStep   = 10'd5;
    localparam logic [CoordW-1:0] ShotRange   = 10'd160;
    localparam logic [CoordW-1:0] AlignBand   = 10'd16;   // Half-width of the shot lane
    localparam logic [CoordW-1:0] ContactDist = 10'd24;

    typedef enum logic [1:0] {
        North = 2'd0,
        West  = 2'd1,
        South = 2'd2,
        East  = 2'd3
    } dir_e;

    // One enemy, 32 bits as read by the host
    typedef struct packed {
        logic [1:0]        rsvd;
        logic              alive;
        dir_e              facing;
        logic [HpW-1:0]    hp;
        logic [CoordW-1:0] x;
        logic [CoordW-1:0] y;
    } enemyRec_t;

    // Player state, 31 bits
    typedef struct packed {
        logic [CoordW-1:0] x;
        logic [CoordW-1:0] y;
        dir_e              facing;
        logic              shot;     // High during the frame a shot is fired
        logic [HpW:0]      damage;
    } playerInfo_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] adr;
    } wbReq_t;

    typedef struct packed {
        logic [31-NumEnemies:0] pad;
        logic [NumEnemies-1:0]  mask;
    } aliveWord_t;

    // Readout word, decoded by address
    typedef union packed {
        enemyRec_t  rec;
        aliveWord_t aliveView;
    } hordeWord_u;

endpackage

/* hdl/spawnAllocator.sv */
// Grants a spawn request to the lowest free slot, registered.
// The grant is a one-cycle one-hot pulse. A request with every slot alive is dropped.
// The alive mask must be settled when the request arrives.
`timescale 1ns/1ps

module spawnAllocator (
    input  logic                           Clk,
    input  logic                           rstN,
    input  logic                           spawnReq,
    input  logic [hordePkg::NumEnemies-1:0] aliveMask,
    output logic [hordePkg::NumEnemies-1:0] spawnGrant
);

    logic [hordePkg::NumEnemies-1:0] grantNext;
    logic                            slotFound;

    // Priority encoder, slot 0 wins
    always_comb
    begin
        grantNext = '0;
        slotFound = 1'b0;
        for (int i = 0; i < hordePkg::NumEnemies; i++)
        begin
            if (spawnReq && !slotFound && !aliveMask[i])
            begin
                grantNext[i] = 1'b1;
                slotFound    = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            spawnGrant <= '0;
        end
        else
        begin
            spawnGrant <= grantNext;  // Zero when no request
        end
    end

endmodule

/* hdl/enemyUnit.sv */
// One enemy slot. A frame tick starts a judge cycle, then a move cycle.
// Ticks must be at least 3 cycles apart so frames never overlap.
// A spawn pulse reloads the record and cancels a frame in progress.
// Moves past the arena edge leave that coordinate where it was.
`timescale 1ns/1ps

module enemyUnit #(
    parameter int SlotIdx = 0
) (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  spawn,
    input  logic                  frameTick,
    input  hordePkg::playerInfo_t player,
    output hordePkg::enemyRec_t   rec
);

    logic                         judgePend;
    logic                         movePend;
    logic                         hitPend;   // Knockback owed in the move cycle
    hordePkg::dir_e               knockDir;

    logic                         uRight, uLeft, uBelow, uAbove;
    logic [hordePkg::CoordW-1:0]  dx, dy;
    logic                         hit;
    logic [2*hordePkg::CoordW-1:0] dxSq, dySq;
    logic [2*hordePkg::CoordW:0]  distSq;

    hordePkg::dir_e               moveDir;
    logic [hordePkg::CoordW-1:0]  moveStep;
    logic                         moveEn;
    logic [hordePkg::CoordW-1:0]  xNext, yNext;

    function automatic logic [hordePkg::CoordW-1:0] stepUp(
        input logic [hordePkg::CoordW-1:0] c,
        input logic [hordePkg::CoordW-1:0] s,
        input logic [hordePkg::CoordW-1:0] lim
    );
        logic [hordePkg::CoordW:0] sum;
        sum = {1'b0, c} + {1'b0, s};
        return (sum > {1'b0, lim}) ? c : sum[hordePkg::CoordW-1:0];
    endfunction

    function automatic logic [hordePkg::CoordW-1:0] stepDown(
        input logic [hordePkg::CoordW-1:0] c,
        input logic [hordePkg::CoordW-1:0] s
    );
        return (c < s) ? c : c - s;
    endfunction

    // Position relative to the player
    assign uRight = rec.x > player.x;
    assign uLeft  = rec.x < player.x;
    assign uBelow = rec.y > player.y;
    assign uAbove = rec.y < player.y;
    assign dx     = uRight ? rec.x - player.x : player.x - rec.x;
    assign dy     = uBelow ? rec.y - player.y : player.y - rec.y;

    assign dxSq   = {{hordePkg::CoordW{1'b0}}, dx} * {{hordePkg::CoordW{1'b0}}, dx};
    assign dySq   = {{hordePkg::CoordW{1'b0}}, dy} * {{hordePkg::CoordW{1'b0}}, dy};
    assign distSq = {1'b0, dxSq} + {1'b0, dySq};

    // Shot lane check along the player's facing
    always_comb
    begin
        hit = 1'b0;
        if (player.shot)
        begin
            case (player.facing)
                hordePkg::North: hit = uAbove && dy <= hordePkg::ShotRange
                                       && dx <= hordePkg::AlignBand;
                hordePkg::South: hit = uBelow && dy <= hordePkg::ShotRange
                                       && dx <= hordePkg::AlignBand;
                hordePkg::West:  hit = uLeft && dx <= hordePkg::ShotRange
                                       && dy <= hordePkg::AlignBand;
                default:         hit = uRight && dx <= hordePkg::ShotRange
                                       && dy <= hordePkg::AlignBand;
            endcase
        end
    end

    // Knockback wins over chasing
    always_comb
    begin
        moveEn   = 1'b1;
        moveDir  = knockDir;
        moveStep = hordePkg::KnockStep;
        if (!hitPend)
        begin
            moveStep = hordePkg::ChaseStep;
            if (distSq <= (2*hordePkg::CoordW+1)'(hordePkg::ContactDist)
                          * (2*hordePkg::CoordW+1)'(hordePkg::ContactDist))
                moveEn = 1'b0;                          // In contact, hold
            else if (dx >= dy)
                moveDir = uRight ? hordePkg::West : hordePkg::East;   // X on a tie
            else
                moveDir = uBelow ? hordePkg::North : hordePkg::South;
        end

        xNext = rec.x;
        yNext = rec.y;
        if (moveEn)
        begin
            case (moveDir)
                hordePkg::North: yNext = stepDown(rec.y, moveStep);
                hordePkg::South: yNext = stepUp(rec.y, moveStep, hordePkg::ArenaYMax);
                hordePkg::West:  xNext = stepDown(rec.x, moveStep);
                default:         xNext = stepUp(rec.x, moveStep, hordePkg::ArenaXMax);
            endcase
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            rec       <= '0;
            judgePend <= 1'b0;
            movePend  <= 1'b0;
            hitPend   <= 1'b0;
        end
        else if (spawn)
        begin
            rec.rsvd  <= '0;
            rec.alive <= 1'b1;
            rec.hp    <= hordePkg::SpawnHp;
            rec.y     <= hordePkg::SpawnY;
            if (SlotIdx % 2 == 0)
            begin
                rec.facing <= hordePkg::West;
                rec.x      <= hordePkg::SpawnXEven;
            end
            else
            begin
                rec.facing <= hordePkg::East;
                rec.x      <= hordePkg::SpawnXOdd;
            end
            judgePend <= 1'b0;
            movePend  <= 1'b0;
            hitPend   <= 1'b0;
        end
        else
        begin
            judgePend <= frameTick && rec.alive;
            movePend  <= judgePend;
            if (judgePend && hit)
            begin
                if ({1'b0, rec.hp} <= player.damage)
                begin
                    rec.hp    <= '0;
                    rec.alive <= 1'b0;  // Slot free for the allocator
                end
                else
                begin
                    rec.hp   <= rec.hp - player.damage[hordePkg::HpW-1:0];
                    hitPend  <= 1'b1;
                    knockDir <= player.facing;
                end
            end
            if (movePend && rec.alive)
            begin
                rec.x   <= xNext;
                rec.y   <= yNext;
                hitPend <= 1'b0;
                if (!hitPend && moveEn)
                    rec.facing <= moveDir;  // Face the way it chases
            end
        end
    end

endmodule

/* hdl/hordeStatusPort.sv */
// Wishbone classic slave, read only. Writes get an ack and change nothing.
// Address below NumEnemies reads a record, NumEnemies reads the alive mask, others read zero.
// The ack follows the request by one cycle and lasts one cycle.
`timescale 1ns/1ps

module hordeStatusPort (
    input  logic                  Clk,
    input  logic                  rstN,
    input  hordePkg::wbReq_t      wb,
    input  hordePkg::enemyRec_t   recs [hordePkg::NumEnemies],
    output hordePkg::hordeWord_u  wbData,
    output logic                  wbAck
);

    logic [hordePkg::NumEnemies-1:0] aliveMask;
    hordePkg::hordeWord_u            readWord;
    logic                            access;

    always_comb
    begin
        for (int i = 0; i < hordePkg::NumEnemies; i++)
            aliveMask[i] = recs[i].alive;
    end

    // Address decode
    always_comb
    begin
        readWord = '0;
        if (wb.adr < 4'(hordePkg::NumEnemies))
        begin
            readWord.rec = recs[wb.adr];
        end
        else if (wb.adr == 4'(hordePkg::NumEnemies))
        begin
            readWord.aliveView.mask = aliveMask;  // Upper bits stay zero
        end
    end

    // New cycle only while no ack is out
    assign access = wb.cyc && wb.stb && !wbAck;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            wbAck <= 1'b0;
        end
        else
        begin
            wbAck <= access;
        end
    end

    always_ff @(posedge Clk)
    begin
        if (access && !wb.we)
        begin
            wbData <= readWord;
        end
    end

endmodule

/* hdl/hordeTop.sv */
// Enemy horde top level.
// frameTick and spawnReq are one-cycle pulses, applied at least 3 cycles apart.
// A spawned enemy shows alive two cycles after its request.
`timescale 1ns/1ps

module hordeTop (
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic                  frameTick,
    input  logic                  spawnReq,
    input  hordePkg::playerInfo_t player,
    input  hordePkg::wbReq_t      wb,
    output hordePkg::hordeWord_u  wbData,
    output logic                  wbAck
);

    logic [hordePkg::NumEnemies-1:0] spawnGrant;
    logic [hordePkg::NumEnemies-1:0] aliveMask;
    hordePkg::enemyRec_t             recs [hordePkg::NumEnemies];

    spawnAllocator alloc0 (
        .Clk        (Clk),
        .rstN       (rstN),
        .spawnReq   (spawnReq),
        .aliveMask  (aliveMask),
        .spawnGrant (spawnGrant)
    );

    for (genvar i = 0; i < hordePkg::NumEnemies; i++)
    begin : gUnit
        enemyUnit #(
            .SlotIdx (i)
        ) unit0 (
            .Clk       (Clk),
            .rstN      (rstN),
            .spawn     (spawnGrant[i]),
            .frameTick (frameTick),
            .player    (player),
            .rec       (recs[i])
        );

        assign aliveMask[i] = recs[i].alive;  // Feeds the allocator
    end

    hordeStatusPort status0 (
        .Clk    (Clk),
        .rstN   (rstN),
        .wb     (wb),
        .recs   (recs),
        .wbData (wbData),
        .wbAck  (wbAck)
    );

endmodule

/* test/hordeTb_props.sv */
// Concurrent checks on the Wishbone handshake and on alive-mask timing, bound to hordeTop.
`timescale 1ns/1ps

module hordeTb_props (
    input logic                            Clk,
    input logic                            rstN,
    input logic                            frameTick,
    input logic                            spawnReq,
    input hordePkg::wbReq_t                wb,
    input logic                            wbAck,
    input logic [hordePkg::NumEnemies-1:0] aliveMask
);

    int failCount = 0;

    // Ack answers a request seen on the previous edge
    ackAfterReq: assert property (@(posedge Clk) disable iff (!rstN)
        wbAck |-> $past(wb.cyc && wb.stb))
    else
    begin
        failCount++;
        $error("wbAck rose without cyc and stb on the cycle before");
    end

    ackOneCycle: assert property (@(posedge Clk) disable iff (!rstN)
        wbAck |=> !wbAck)
    else
    begin
        failCount++;
        $error("wbAck stayed high for two cycles in a row");
    end

    // Spawn and frame both land two edges after the pulse
    maskTiming: assert property (@(posedge Clk) disable iff (!rstN)
        (aliveMask != $past(aliveMask)) |-> ($past(spawnReq, 2) || $past(frameTick, 2)))
    else
    begin
        failCount++;
        $error("alive mask changed without a spawn request or frame tick two cycles earlier");
    end

endmodule

bind hordeTop hordeTb_props props0 (
    .Clk       (Clk),
    .rstN      (rstN),
    .frameTick (frameTick),
    .spawnReq  (spawnReq),
    .wb        (wb),
    .wbAck     (wbAck),
    .aliveMask (aliveMask)
);

/* test/hordeTb.sv */
// Testbench for the enemy horde. Keeps its own model of every slot and reads the DUT over Wishbone.
// Only slots 0 to 2 see traffic. Damage comes from a seeded $random, 20 to 60.
// Needs assertions enabled in the simulator.
`timescale 1ns/1ps

module hordeTb;

    localparam int ResetCycles   = 3;
    localparam int CycleBudget   = 10 + 10 + 40 + 50 + 45 + 130;  // Reset, then tests 1 to 5
    localparam int TimeoutCycles = 2 * CycleBudget;
    localparam logic [3:0] MaskAdr = 4'(hordePkg::NumEnemies);

    localparam int XMax    = int'(hordePkg::ArenaXMax);
    localparam int YMax    = int'(hordePkg::ArenaYMax);
    localparam int Range   = int'(hordePkg::ShotRange);
    localparam int Band    = int'(hordePkg::AlignBand);
    localparam int Contact = int'(hordePkg::ContactDist);

    logic                  Clk;
    logic                  rstN;
    logic                  frameTick;
    logic                  spawnReq;
    hordePkg::playerInfo_t player;
    hordePkg::wbReq_t      wb;
    hordePkg::hordeWord_u  wbData;
    logic                  wbAck;

    int seed = 32'ha860;
    int errCount = 0;
    int checkCount = 0;
    int testErrs = 0;
    int cycles = 0;
    int damage;
    int shots;

    // Expected state of each slot
    int             mX     [hordePkg::NumEnemies];
    int             mY     [hordePkg::NumEnemies];
    int             mHp    [hordePkg::NumEnemies];
    hordePkg::dir_e mFace  [hordePkg::NumEnemies];
    bit             mAlive [hordePkg::NumEnemies];

    hordeTop dut0 (
        .Clk       (Clk),
        .rstN      (rstN),
        .frameTick (frameTick),
        .spawnReq  (spawnReq),
        .player    (player),
        .wb        (wb),
        .wbData    (wbData),
        .wbAck     (wbAck)
    );

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk)
    begin
        cycles++;
        if (cycles >= TimeoutCycles)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic int absInt(int v);
        return (v < 0) ? -v : v;
    endfunction

    // A step past the arena edge leaves the coordinate alone
    function automatic int stepCoord(int v, int s, int lim);
        return (v + s < 0 || v + s > lim) ? v : v + s;
    endfunction

    task automatic moveModel(int i, hordePkg::dir_e dir, int s);
        case (dir)
            hordePkg::North: mY[i] = stepCoord(mY[i], -s, YMax);
            hordePkg::South: mY[i] = stepCoord(mY[i], s, YMax);
            hordePkg::West:  mX[i] = stepCoord(mX[i], -s, XMax);
            default:         mX[i] = stepCoord(mX[i], s, XMax);
        endcase
    endtask

    task automatic modelSpawn();
        for (int i = 0; i < hordePkg::NumEnemies; i++)
        begin
            if (!mAlive[i])
            begin
                mAlive[i] = 1'b1;
                mHp[i]    = int'(hordePkg::SpawnHp);
                mY[i]     = int'(hordePkg::SpawnY);
                mX[i]     = (i % 2 == 0) ? int'(hordePkg::SpawnXEven) : int'(hordePkg::SpawnXOdd);
                mFace[i]  = (i % 2 == 0) ? hordePkg::West : hordePkg::East;
                break;
            end
        end
    endtask

    task automatic modelFrame(int px, int py, hordePkg::dir_e pf, bit shot, int dmg);
        int dx;
        int dy;
        bit hit;
        for (int i = 0; i < hordePkg::NumEnemies; i++)
        begin
            dx = mX[i] - px;  // Positive when right of the player
            dy = mY[i] - py;  // Positive when below
            case (pf)
                hordePkg::North: hit = dy < 0 && -dy <= Range && absInt(dx) <= Band;
                hordePkg::South: hit = dy > 0 && dy <= Range && absInt(dx) <= Band;
                hordePkg::West:  hit = dx < 0 && -dx <= Range && absInt(dy) <= Band;
                default:         hit = dx > 0 && dx <= Range && absInt(dy) <= Band;
            endcase
            hit = hit && shot;
            if (!mAlive[i])
                continue;
            if (hit && mHp[i] <= dmg)
            begin
                mHp[i]    = 0;
                mAlive[i] = 1'b0;
            end
            else if (hit)
            begin
                mHp[i] -= dmg;
                moveModel(i, pf, int'(hordePkg::KnockStep));  // Pushed the way the shot flies
            end
            else if (dx * dx + dy * dy > Contact * Contact)
            begin
                if (absInt(dx) >= absInt(dy))
                    mFace[i] = (dx > 0) ? hordePkg::West : hordePkg::East;
                else
                    mFace[i] = (dy > 0) ? hordePkg::North : hordePkg::South;
                moveModel(i, mFace[i], int'(hordePkg::ChaseStep));
            end
        end
    endtask

    function automatic hordePkg::enemyRec_t expRec(int i);
        hordePkg::enemyRec_t r;
        r        = '0;
        r.alive  = mAlive[i];
        r.facing = mFace[i];
        r.hp     = hordePkg::HpW'(mHp[i]);
        r.x      = hordePkg::CoordW'(mX[i]);
        r.y      = hordePkg::CoordW'(mY[i]);
        return r;
    endfunction

    task automatic checkWord(string name, logic [31:0] exp, logic [31:0] act);
        checkCount++;
        assert (act === exp)
        else
        begin
            errCount++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // Classic single access, held until the ack shows up
    task automatic wbAccess(input logic we, input logic [3:0] adr,
                            output hordePkg::hordeWord_u data);
        @(posedge Clk);
        wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr};
        do
            @(negedge Clk);
        while (!wbAck);
        data = wbData;
        @(posedge Clk);
        wb <= '0;
    endtask

    task automatic checkSlot(int i);
        hordePkg::hordeWord_u word;
        wbAccess(1'b0, 4'(i), word);
        checkWord($sformatf("wbData.rec[%0d]", i), expRec(i), word);
    endtask

    task automatic checkMask();
        hordePkg::hordeWord_u word;
        logic [31:0] m;
        m = '0;
        for (int i = 0; i < hordePkg::NumEnemies; i++)
            m[i] = mAlive[i];
        wbAccess(1'b0, MaskAdr, word);
        checkWord("wbData.aliveView", m, word);
    endtask

    task automatic checkAll();
        for (int i = 0; i < 3; i++)
            checkSlot(i);
        checkMask();
    endtask

    task automatic spawnOne();
        @(posedge Clk);
        spawnReq <= 1'b1;
        @(posedge Clk);
        spawnReq <= 1'b0;
        repeat (3) @(posedge Clk);  // Alive two edges after the request
        modelSpawn();
    endtask

    task automatic runFrame(int px, int py, hordePkg::dir_e pf, bit shot, int dmg);
        @(posedge Clk);
        player <= '{x: hordePkg::CoordW'(px), y: hordePkg::CoordW'(py), facing: pf,
                    shot: shot, damage: (hordePkg::HpW + 1)'(dmg)};
        frameTick <= 1'b1;
        @(posedge Clk);
        frameTick <= 1'b0;
        repeat (3) @(posedge Clk);  // Judge, then move
        modelFrame(px, py, pf, shot, dmg);
    endtask

    task automatic endTest(string name);
        $display("%s: %s", name, (errCount == testErrs) ? "ok" : "mismatches seen");
        testErrs = errCount;
    endtask

    initial
    begin
        hordePkg::hordeWord_u word;
        rstN      = 1'b0;
        frameTick = 1'b0;
        spawnReq  = 1'b0;
        player    = '0;
        wb        = '0;
        for (int i = 0; i < hordePkg::NumEnemies; i++)
        begin
            mAlive[i] = 1'b0;
            mX[i]     = 0;
            mY[i]     = 0;
            mHp[i]    = 0;
            mFace[i]  = hordePkg::North;
        end
        repeat (ResetCycles) @(posedge Clk);
        rstN <= 1'b1;

        @(negedge Clk);
        checkWord("wbAck", 32'd0, {31'd0, wbAck});
        checkMask();
        endTest("test 1 reset state");

        repeat (3) spawnOne();
        checkAll();
        endTest("test 2 spawn into slots 0 to 2");

        runFrame(300, 240, hordePkg::East, 1'b0, 0);
        checkAll();
        runFrame(mX[0], mY[0], hordePkg::East, 1'b0, 0);  // Player on top of slot 0
        checkAll();
        endTest("test 3 chase and contact stop");

        damage = 20 + int'($unsigned($random(seed)) % 41);
        runFrame(500, 240, hordePkg::East, 1'b1, damage);
        checkAll();
        runFrame(mX[1] + 40, 240, hordePkg::East, 1'b1, damage);  // Slot 1 in range but behind
        checkAll();
        endTest("test 4 shot and knockback");

        shots = 0;
        while (mAlive[0] && shots < 8)
        begin
            damage = 20 + int'($unsigned($random(seed)) % 41);
            runFrame(500, 240, hordePkg::East, 1'b1, damage);
            checkSlot(0);
            shots++;
        end
        checkAll();
        spawnOne();
        checkAll();
        wbAccess(1'b1, 4'd0, word);  // Write is acked and ignored
        checkAll();
        endTest("test 5 death, respawn and write");

        errCount += dut0.props0.failCount;
        $display("checks %0d, errors %0d", checkCount, errCount);
        if (errCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb.f */
hdl/hordePkg.sv
hdl/spawnAllocator.sv
hdl/enemyUnit.sv
hdl/hordeStatusPort.sv
hdl/hordeTop.sv
test/hordeTb_props.sv
test/hordeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the horde testbench with Verilator, runs it and checks the log for the pass message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module hordeTb -f tb.f -o hordeSim \
    && ./obj_dir/hordeSim +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
